/* pim_aes.f */
rtl/pim_aes_pkg.sv
rtl/round_ctrl.sv
rtl/state_feeder.sv
rtl/plane_collector.sv
rtl/array_addr_gen.sv
rtl/pim_aes_top.sv
test/pim_aes_props.sv
test/tb_pim_aes.sv

/* rtl/array_addr_gen.sv */
// per-lane array addresses from the group key table or the key-added bytes
module array_addr_gen
    import pim_aes_pkg::*;
#(
    parameter int NUM_GROUPS = NUM_GROUPS_DEF
) (
    input  phase_e      phase,
    input  grp_idx_t    grp,
    input  rio_bus_t    ark,
    output array_addr_t addr
);

    lane_addr_t key_loc;

    // four groups share a row, demux counts down from 7
    always_comb begin
        key_loc = '0;
        if (int'(grp) < NUM_GROUPS) begin
            key_loc.demux = 3'd7 - {1'b0, grp[1:0]};
            key_loc.row   = {4'b0, grp[3:2]};
        end
    end

    always_comb begin
        addr = '0;
        case (phase)
            PH_COMPUTE: begin
                for (int j = 0; j < NUM_LANES; j++) begin
                    addr[j] = key_loc;
                end
            end
            PH_LOOKUP: begin
                // top two bits pick the demux, the rest the row
                for (int j = 0; j < NUM_LANES; j++) begin
                    addr[j].demux = {1'b0, ark[j][7:6]};
                    addr[j].row   = ark[j][5:0];
                end
            end
            default: ;
        endcase
    end

endmodule

/* rtl/pim_aes_pkg.sv */
// widths, state and bus types, lane address struct, phase enum and group count
package pim_aes_pkg;

    // --------------------
    // sizes
    // --------------------
    localparam int NUM_LANES      = 16;
    localparam int NUM_BEATS      = 8;
    localparam int NUM_GROUPS_DEF = 11;

    // --------------------
    // data types
    // --------------------

    // byte 0 sits in bits 127..120
    typedef logic [127:0] aes_state_t;

    // one array input word
    typedef logic [15:0] beat_t;

    // returned bytes, lane 0 most significant
    typedef logic [0:NUM_LANES-1][7:0] rio_bus_t;

    // per-lane array address
    typedef struct packed {
        logic [2:0] demux;
        logic [5:0] row;
    } lane_addr_t;

    typedef lane_addr_t [0:NUM_LANES-1] array_addr_t;

    // --------------------
    // control types
    // --------------------
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_COMPUTE,
        PH_LOOKUP,
        PH_MIX,
        PH_OUT
    } phase_e;

    typedef logic [3:0] grp_idx_t;
    typedef logic [2:0] beat_idx_t;

endpackage

/* rtl/pim_aes_top.sv */
// top level of the round sequencer with control, feeder, collector and address blocks
module pim_aes_top
    import pim_aes_pkg::*;
#(
    parameter int NUM_GROUPS = NUM_GROUPS_DEF
) (
    input  logic        CLK,
    input  logic        rst,
    input  logic        start,
    input  aes_state_t  din,
    input  rio_bus_t    rio,
    input  logic        rd_done,
    output logic        io_en,
    output logic        sel_ad0,
    output logic        dvld,
    output logic        busy,
    output beat_t       wl_data,
    output array_addr_t addr,
    output aes_state_t  dout
);

    phase_e    phase;
    grp_idx_t  grp;
    beat_idx_t beat;
    logic      capture;
    logic      lookup_done;
    rio_bus_t  ark;

    // --------------------
    // control
    // --------------------
    round_ctrl #(
        .NUM_GROUPS (NUM_GROUPS)
    ) u_ctrl (
        .CLK         (CLK),
        .rst         (rst),
        .start       (start),
        .rd_done     (rd_done),
        .phase       (phase),
        .grp         (grp),
        .beat        (beat),
        .capture     (capture),
        .lookup_done (lookup_done),
        .io_en       (io_en),
        .sel_ad0     (sel_ad0),
        .busy        (busy),
        .dvld        (dvld)
    );

    // --------------------
    // datapath
    // --------------------
    state_feeder u_feeder (
        .CLK         (CLK),
        .rst         (rst),
        .start       (start),
        .lookup_done (lookup_done),
        .phase       (phase),
        .beat        (beat),
        .din         (din),
        .rio         (rio),
        .wl_data     (wl_data)
    );

    plane_collector u_collector (
        .CLK     (CLK),
        .rst     (rst),
        .capture (capture),
        .phase   (phase),
        .beat    (beat),
        .rio     (rio),
        .ark     (ark),
        .dout    (dout)
    );

    array_addr_gen #(
        .NUM_GROUPS (NUM_GROUPS)
    ) u_addr (
        .phase (phase),
        .grp   (grp),
        .ark   (ark),
        .addr  (addr)
    );

endmodule

/* rtl/plane_collector.sv */
// bit-plane transpose into key-added bytes and the result register
module plane_collector
    import pim_aes_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       capture,
    input  phase_e     phase,
    input  beat_idx_t  beat,
    input  rio_bus_t   rio,
    output rio_bus_t   ark,
    output aes_state_t dout
);

    localparam int        HALF      = NUM_LANES / 2;
    localparam beat_idx_t LAST_BEAT = beat_idx_t'(NUM_BEATS - 1);

    rio_bus_t ark_next;

    // --------------------
    // transpose
    // --------------------

    // beat k reads bit 7-k of every lane
    // lanes 0..7 build byte 2k, lanes 8..15 build byte 2k+1
    always_comb begin
        ark_next = ark;
        if (phase == PH_IDLE) begin
            ark_next = '0;
        end else if (capture) begin
            for (int i = 0; i < HALF; i++) begin
                ark_next[{beat, 1'b0}][i] = rio[i][~beat];
                ark_next[{beat, 1'b1}][i] = rio[HALF + i][~beat];
            end
        end
    end

    always_ff @(posedge CLK) begin
        ark <= ark_next;
    end

    // --------------------
    // result
    // --------------------

    // the final plane completes the bytes on the same edge that enters PH_OUT
    // earlier groups pass through here too, dout is valid at dvld
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            dout <= '0;
        end else if (capture && beat == LAST_BEAT) begin
            dout <= ark_next;
        end
    end

endmodule

/* rtl/round_ctrl.sv */
// phase FSM, group and beat counters, io_en pulse rule, busy and dvld
module round_ctrl
    import pim_aes_pkg::*;
#(
    parameter int NUM_GROUPS = NUM_GROUPS_DEF
) (
    input  logic      CLK,
    input  logic      rst,
    input  logic      start,
    input  logic      rd_done,
    output phase_e    phase,
    output grp_idx_t  grp,
    output beat_idx_t beat,
    output logic      capture,
    output logic      lookup_done,
    output logic      io_en,
    output logic      sel_ad0,
    output logic      busy,
    output logic      dvld
);

    localparam grp_idx_t  LAST_GRP  = grp_idx_t'(NUM_GROUPS - 1);
    localparam beat_idx_t LAST_BEAT = beat_idx_t'(NUM_BEATS - 1);

    phase_e phase_nxt;
    logic   io_req;

    // rd_done qualified by phase
    assign capture     = rd_done && (phase == PH_COMPUTE);
    assign lookup_done = rd_done && (phase == PH_LOOKUP);
    assign sel_ad0     = (phase == PH_COMPUTE);

    // --------------------
    // next phase
    // --------------------
    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_IDLE: begin
                if (start) begin
                    phase_nxt = PH_COMPUTE;
                end
            end
            PH_COMPUTE: begin
                // last plane of the group decides lookup or output
                if (capture && beat == LAST_BEAT) begin
                    phase_nxt = (grp == LAST_GRP) ? PH_OUT : PH_LOOKUP;
                end
            end
            PH_LOOKUP: begin
                if (lookup_done) begin
                    phase_nxt = PH_MIX;
                end
            end
            PH_MIX:  phase_nxt = PH_COMPUTE;
            PH_OUT:  phase_nxt = PH_IDLE;
            default: phase_nxt = PH_IDLE;
        endcase
    end

    // one request on entry to compute or lookup, one after each non-final plane
    assign io_req = ((phase_nxt != phase) &&
                     (phase_nxt == PH_COMPUTE || phase_nxt == PH_LOOKUP)) ||
                    (capture && beat != LAST_BEAT);

    // --------------------
    // registers
    // --------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            phase <= PH_IDLE;
            grp   <= '0;
            beat  <= '0;
            io_en <= 1'b0;
            busy  <= 1'b0;
            dvld  <= 1'b0;
        end else begin
            phase <= phase_nxt;
            io_en <= io_req;
            dvld  <= (phase_nxt == PH_OUT);
            if (phase == PH_IDLE && start) begin
                busy <= 1'b1;
            end else if (phase_nxt == PH_OUT) begin
                busy <= 1'b0;
            end
            case (phase)
                PH_IDLE: begin
                    grp  <= '0;
                    beat <= '0;
                end
                PH_COMPUTE: begin
                    // wraps to 0 after the eighth plane
                    if (capture) begin
                        beat <= beat + 1'b1;
                    end
                end
                PH_MIX: begin
                    grp  <= grp + 1'b1;
                    beat <= '0;
                end
                default: ;
            endcase
        end
    end

endmodule

/* rtl/state_feeder.sv */
// round state register and MSB-first beat selection for the array input
module state_feeder
    import pim_aes_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       start,
    input  logic       lookup_done,
    input  phase_e     phase,
    input  beat_idx_t  beat,
    input  aes_state_t din,
    input  rio_bus_t   rio,
    output beat_t      wl_data
);

    aes_state_t state;

    // --------------------
    // round state
    // --------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            state <= '0;
        end else if (phase == PH_IDLE && start) begin
            state <= din;
        end else if (lookup_done) begin
            // looked-up bytes become the next round input
            state <= rio;
        end
    end

    // --------------------
    // beat slice
    // --------------------

    // beat 0 carries bits 127..112
    assign wl_data = (phase == PH_COMPUTE) ? state[127 - 16 * int'(beat) -: 16] : '0;

endmodule

/* test/pim_aes_props.sv */
// concurrent checks on the round controller pulses and levels
module pim_aes_props
    import pim_aes_pkg::*;
(
    input logic CLK,
    input logic rst,
    input logic io_en,
    input logic sel_ad0,
    input logic busy,
    input logic dvld
);

    int fail_cnt = 0;

    // one array request per pulse
    io_en_pulse: assert property (@(posedge CLK) disable iff (rst) io_en |=> !io_en)
        else begin
            fail_cnt++;
            $error("io_en high on two cycles in a row");
        end

    dvld_pulse: assert property (@(posedge CLK) disable iff (rst) dvld |=> !dvld)
        else begin
            fail_cnt++;
            $error("dvld longer than one cycle");
        end

    busy_fall: assert property (@(posedge CLK) disable iff (rst) $fell(busy) |-> dvld)
        else begin
            fail_cnt++;
            $error("busy fell without dvld");
        end

    // compute phase only exists inside a run
    sel_phase: assert property (@(posedge CLK) disable iff (rst) sel_ad0 |-> busy)
        else begin
            fail_cnt++;
            $error("sel_ad0 high while no run is active");
        end

endmodule

/* test/tb_pim_aes.sv */
// testbench with clock, reset, array model, reference function, checks and watchdog
module tb_pim_aes
    import pim_aes_pkg::*;
();

    localparam int RUNS     = 20;
    localparam int ACCESSES = NUM_BEATS * NUM_GROUPS_DEF + NUM_GROUPS_DEF - 1;
    localparam int WATCHDOG = RUNS * NUM_GROUPS_DEF * 9 * 8 * 10 + 5000;

    logic        CLK;
    logic        rst;
    logic        start;
    aes_state_t  din;
    rio_bus_t    rio;
    logic        rd_done;
    logic        io_en, sel_ad0, dvld, busy;
    beat_t       wl_data;
    array_addr_t addr;
    aes_state_t  dout;

    logic [127:0] key_tbl [NUM_GROUPS_DEF];
    aes_state_t   exp_q [$];
    logic [31:0]  rng;
    int           mismatches, errors, io_cnt, cmp_cnt, runs_done;
    logic         started, run_active, pending;

    pim_aes_top #(.NUM_GROUPS(NUM_GROUPS_DEF)) u_dut (.*);

    bind round_ctrl pim_aes_props u_props (.*);

    always #5 CLK = ~CLK;

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = '0;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i])
                p = p ^ x;
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // inverse as v^254, then the affine map
    function automatic logic [7:0] sbox(input logic [7:0] v);
        logic [7:0] sq;
        logic [7:0] inv;
        sq  = v;
        inv = 8'h01;
        for (int i = 0; i < 7; i++) begin
            sq  = gf_mul(sq, sq);
            inv = gf_mul(inv, sq);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
               ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    // expected dout, group by group
    function automatic aes_state_t ref_result(input aes_state_t d);
        aes_state_t st;
        aes_state_t ark;
        int         j;
        st  = d;
        ark = '0;
        for (int g = 0; g < NUM_GROUPS_DEF; g++) begin
            // byte 2k+h bit i comes from lane 8h+i
            for (int k = 0; k < NUM_BEATS; k++) begin
                for (int h = 0; h < 2; h++) begin
                    for (int i = 0; i < 8; i++) begin
                        j = 8 * h + i;
                        ark[120 - 8 * (2 * k + h) + i] = st[127 - 16 * k - j] ^
                                                         key_tbl[g][127 - 16 * k - j];
                    end
                end
            end
            if (g < NUM_GROUPS_DEF - 1) begin
                for (int b = 0; b < NUM_LANES; b++)
                    st[127 - 8 * b -: 8] = sbox(ark[127 - 8 * b -: 8]);
            end
        end
        return ark;
    endfunction

    // --------------------
    // array model
    // --------------------
    initial begin : array_model
        rio_bus_t resp;
        int       g;
        int       k;
        int       dec;
        forever begin
            @(negedge CLK);
            if (io_en === 1'b1) begin
                if (sel_ad0) begin
                    g = cmp_cnt / NUM_BEATS;
                    k = cmp_cnt % NUM_BEATS;
                    cmp_cnt++;
                    for (int j = 0; j < NUM_LANES; j++) begin
                        dec = 4 * int'(addr[j].row) + 7 - int'(addr[j].demux);
                        assert (addr[j].demux >= 4 && dec == g) else begin
                            mismatches++;
                            $display("MISMATCH at %0t: lane %0d key group %0d, expected %0d",
                                     $time, j, dec, g);
                        end
                        rng = xorshift(rng);
                        resp[j] = rng[7:0];
                        resp[j][7 - k] = wl_data[15 - j] ^ key_tbl[g][127 - 16 * k - j];
                    end
                end else begin
                    for (int j = 0; j < NUM_LANES; j++) begin
                        assert (addr[j].demux <= 3) else begin
                            mismatches++;
                            $display("MISMATCH at %0t: lane %0d lookup demux %0d above 3",
                                     $time, j, addr[j].demux);
                        end
                        resp[j] = sbox({addr[j].demux[1:0], addr[j].row});
                    end
                end
                rng = xorshift(rng);
                repeat (1 + rng[1:0]) @(posedge CLK);
                rd_done <= 1'b1;
                rio     <= resp;
                @(posedge CLK);
                rd_done <= 1'b0;
                rio     <= '0;
            end
        end
    end

    // --------------------
    // monitors
    // --------------------
    always @(negedge CLK) begin
        if (!rst && !started) begin
            assert (io_en === 1'b0 && dvld === 1'b0 && busy === 1'b0 && sel_ad0 === 1'b0
                    && dout === '0) else begin
                mismatches++;
                $display("MISMATCH at %0t: outputs not at reset values before start", $time);
            end
        end
        if (io_en === 1'b1) begin
            assert (!pending) else begin
                errors++;
                $display("ERROR at %0t: io_en pulsed while a read was still pending", $time);
            end
            pending = 1'b1;
            io_cnt++;
        end else if (rd_done === 1'b1) begin
            pending = 1'b0;
        end
    end

    always @(negedge CLK) begin : compare_result
        aes_state_t expected;
        if (run_active && dvld !== 1'b1) begin
            assert (busy === 1'b1) else begin
                errors++;
                $display("ERROR at %0t: busy low while the run is still going", $time);
            end
        end
        if (dvld === 1'b1) begin
            expected = (exp_q.size() != 0) ? exp_q.pop_front() : 'x;
            assert (dout === expected && busy === 1'b0) else begin
                mismatches++;
                $display("MISMATCH at %0t: dout %h busy %b, expected %h busy 0",
                         $time, dout, busy, expected);
            end
            assert (io_cnt == ACCESSES) else begin
                errors++;
                $display("ERROR at %0t: run made %0d array requests instead of %0d",
                         $time, io_cnt, ACCESSES);
            end
            run_active = 1'b0;
            runs_done++;
        end
    end

    // --------------------
    // stimulus
    // --------------------
    initial begin
        aes_state_t d;
        CLK        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        din        = '0;
        rio        = '0;
        rd_done    = 1'b0;
        rng        = 32'h23c2;
        mismatches = 0;
        errors     = 0;
        io_cnt     = 0;
        cmp_cnt    = 0;
        runs_done  = 0;
        started    = 1'b0;
        run_active = 1'b0;
        pending    = 1'b0;
        for (int g = 0; g < NUM_GROUPS_DEF; g++) begin
            for (int w = 0; w < 4; w++) begin
                rng = xorshift(rng);
                key_tbl[g][32 * w +: 32] = rng;
            end
        end
        repeat (10) @(posedge CLK);
        rst <= 1'b0;
        repeat (5) @(posedge CLK);
        for (int r = 0; r < RUNS; r++) begin
            for (int w = 0; w < 4; w++) begin
                rng = xorshift(rng);
                d[32 * w +: 32] = rng;
            end
            exp_q.push_back(ref_result(d));
            start   <= 1'b1;
            din     <= d;
            io_cnt  = 0;
            cmp_cnt = 0;
            started = 1'b1;
            @(posedge CLK);
            start      <= 1'b0;
            run_active = 1'b1;
            // a second start mid-run must be ignored
            repeat (25) @(posedge CLK);
            rng = xorshift(rng);
            start <= 1'b1;
            din   <= {4{rng}};
            @(posedge CLK);
            start <= 1'b0;
            wait (runs_done == r + 1);
            @(posedge CLK);
        end
        repeat (5) @(posedge CLK);
        errors = errors + u_dut.u_ctrl.u_props.fail_cnt;
        $display("errors: %0d mismatches, %0d other failures", mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("ERROR: watchdog expired before all runs finished");
        $display("Finished with errors");
        $finish;
    end

endmodule
